// File: compile.f
hw/soc_pkg.sv
hw/axi_xbar.sv
hw/sram_slave.sv
hw/clint.sv
hw/uart_tx_port.sv
hw/mem_subsys_top.sv
sim/xbar_sva.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(wildcard hw/*.sv) $(wildcard sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int SRAM_ADDR_W = 8;
  localparam int MAX_CYCLES  = 20000;  // About four times the test length

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        check_data;
  } exp_r_t;

  logic             clk;
  logic             rstn;
  soc_pkg::axi_ar_t ar;
  logic             ar_valid;
  logic             ar_ready;
  soc_pkg::axi_r_t  r;
  logic             r_valid;
  logic             r_ready;
  soc_pkg::axi_aw_t aw;
  logic             aw_valid;
  logic             aw_ready;
  soc_pkg::axi_w_t  w;
  logic             w_valid;
  logic             w_ready;
  soc_pkg::axi_b_t  b;
  logic             b_valid;
  logic             b_ready;
  logic [7:0]       uart_data;
  logic             uart_valid;
  logic             skip;

  // Reference model state
  logic [31:0] shadow [0:(1 << SRAM_ADDR_W) - 1];
  exp_r_t      exp_r_q [$];
  logic [1:0]  exp_b_q [$];
  logic [7:0]  exp_uart_q [$];
  logic [31:0] rng = 32'd85082;

  int   cycle = 0;
  int   val_errs = 0;
  int   proto_errs = 0;
  int   exp_skip = 0;
  int   skip_seen = 0;
  int   ar_wait_cycles = 0;
  int   ar_cycle = 0;
  int   w_cycle = 0;
  logic rd_busy = 1'b0;
  logic wr_busy = 1'b0;
  logic w_done = 1'b0;

  mem_subsys_top #(
    .SRAM_ADDR_W (SRAM_ADDR_W)
  ) i_dut (
    .clk        (clk),
    .rstn       (rstn),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .uart_data  (uart_data),
    .uart_valid (uart_valid),
    .skip       (skip)
  );

  bind axi_xbar xbar_sva i_xbar_sva (
    .clk            (clk),
    .rstn           (rstn),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .r_valid        (r_valid),
    .r_ready        (r_ready),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .sram_ar_valid  (sram_ar_valid),
    .clint_ar_valid (clint_ar_valid),
    .sram_aw_valid  (sram_aw_valid),
    .uart_aw_valid  (uart_aw_valid),
    .skip           (skip)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function int rand_below(input int n);
    return int'(next_rand() % n);
  endfunction

  function automatic logic is_sram(input logic [31:0] addr);
    return addr[31:27] == 5'b10000;
  endfunction

  // Upper bits alias onto the same word
  function logic [31:0] sram_addr(input int idx);
    logic [31:0] rv;
    rv = next_rand();
    return {5'b10000, rv[16:0], idx[7:0], 2'b00};
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i])
        res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  task value_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    val_errs++;
  endtask

  task protocol_fault(input string msg);
    $display("At %0t the bus protocol broke: %s", $time, msg);
    proto_errs++;
  endtask

  task finish_run(input logic timed_out);
    int sva_errs;
    sva_errs = i_dut.i_xbar.i_xbar_sva.fail_count;
    $display("Errors: %0d value, %0d protocol, %0d assertion", val_errs, proto_errs, sva_errs);
    if (timed_out || val_errs != 0 || proto_errs != 0 || sva_errs != 0)
      $display("Simulation FAILED");
    else
      $display("Simulation PASSED");
    $finish;
  endtask

  task automatic issue_ar(input logic [31:0] addr);
    exp_r_t e;
    e.data       = '0;
    e.resp       = soc_pkg::RESP_OKAY;
    e.check_data = 1'b1;
    if (is_sram(addr))
      e.data = shadow[addr[SRAM_ADDR_W+1:2]];
    else if (addr == soc_pkg::CLINT_MTIME_ADDR)
      e.check_data = 1'b0;  // Checked for progress instead
    else if (addr != soc_pkg::CLINT_MTIME_ADDR + 32'd4)
      e.resp = soc_pkg::RESP_DECERR;
    if (!is_sram(addr))
      exp_skip++;
    exp_r_q.push_back(e);
    @(negedge clk);
    ar.addr  = addr;
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic take_r(input int gap, output logic [31:0] data);
    repeat (gap) @(negedge clk);
    r_ready = 1'b1;
    @(posedge clk);
    while (!r_valid) @(posedge clk);
    data = r.data;
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input int gap, output logic [31:0] data);
    issue_ar(addr);
    take_r(gap, data);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int gap);
    if (is_sram(addr)) begin
      shadow[addr[SRAM_ADDR_W+1:2]] = merge_word(shadow[addr[SRAM_ADDR_W+1:2]], data, strb);
      exp_b_q.push_back(soc_pkg::RESP_OKAY);
    end else begin
      exp_skip++;
      if (addr == soc_pkg::UART_TX_ADDR) begin
        exp_b_q.push_back(soc_pkg::RESP_OKAY);
        if (strb[0])
          exp_uart_q.push_back(data[7:0]);
      end else begin
        exp_b_q.push_back(soc_pkg::RESP_DECERR);
      end
    end
    @(negedge clk);
    aw.addr  = addr;
    aw_valid = 1'b1;
    w.data   = data;
    w.strb   = strb;
    w_valid  = 1'b1;  // Offered with AW, must wait for it
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
    @(posedge clk);
    while (!w_ready) @(posedge clk);
    @(negedge clk);
    w_valid = 1'b0;
    repeat (gap) @(negedge clk);
    b_ready = 1'b1;
    @(posedge clk);
    while (!b_valid) @(posedge clk);
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  // Compare process
  always @(posedge clk) begin : compare
    exp_r_t     er;
    logic [1:0] eb;
    logic [7:0] eu;
    if (rstn) begin
      rd_busy = 1'b0;
      wr_busy = 1'b0;
      w_done  = 1'b0;
    end else begin
      if (ar_valid && rd_busy)
        ar_wait_cycles++;
      if (ar_valid && ar_ready && rd_busy)
        protocol_fault("AR accepted while a read was outstanding");
      if (r_valid && !rd_busy)
        protocol_fault("r_valid without an accepted read address");
      if (rd_busy && cycle == ar_cycle + 1 && !r_valid)
        protocol_fault("r_valid did not rise one cycle after AR");
      if (r_valid && r_ready && rd_busy) begin
        er = exp_r_q.pop_front();
        if (r.resp !== er.resp)
          value_mismatch($sformatf("read resp %0d, expected %0d", r.resp, er.resp));
        if (er.check_data && r.data !== er.data)
          value_mismatch($sformatf("read data %h, expected %h", r.data, er.data));
        rd_busy = 1'b0;
      end
      if (ar_valid && ar_ready) begin
        rd_busy  = 1'b1;
        ar_cycle = cycle;
      end

      if (w_valid && w_ready && (!wr_busy || w_done))
        protocol_fault("W accepted without a pending AW");
      if (b_valid && !w_done)
        protocol_fault("b_valid before W was accepted");
      if (w_done && cycle == w_cycle + 1 && !b_valid)
        protocol_fault("b_valid did not rise one cycle after W");
      if (b_valid && b_ready && w_done) begin
        eb = exp_b_q.pop_front();
        if (b.resp !== eb)
          value_mismatch($sformatf("write resp %0d, expected %0d", b.resp, eb));
        wr_busy = 1'b0;
        w_done  = 1'b0;
      end
      if (w_valid && w_ready && wr_busy) begin
        w_done  = 1'b1;
        w_cycle = cycle;
      end
      if (aw_valid && aw_ready)
        wr_busy = 1'b1;

      if (uart_valid) begin
        if (exp_uart_q.size() == 0) begin
          protocol_fault("UART strobe that no write asked for");
        end else begin
          eu = exp_uart_q.pop_front();
          if (uart_data !== eu)
            value_mismatch($sformatf("UART byte %h, expected %h", uart_data, eu));
        end
      end
      if (skip)
        skip_seen++;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle == MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      finish_run(1'b1);
    end
  end

  initial begin
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] rv;
    clk      = 1'b0;
    rstn     = 1'b1;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
    @(posedge clk);
    if (r_valid || b_valid || uart_valid || skip || !ar_ready || !aw_ready)
      protocol_fault("outputs not idle after reset");

    // SRAM fill, strobed writes, read back
    for (int i = 0; i < 32; i++)
      write_word(sram_addr(i), next_rand(), 4'hF, 0);
    for (int i = 0; i < 300; i++) begin
      rv = next_rand();
      write_word(sram_addr(rand_below(32)), next_rand(), rv[3:0], rand_below(4));
    end
    for (int i = 0; i < 300; i++)
      read_word(sram_addr(rand_below(32)), rand_below(4), d0);

    // Second AR waits behind a stalled R
    for (int i = 0; i < 20; i++) begin
      issue_ar(sram_addr(rand_below(32)));
      fork
        issue_ar(sram_addr(rand_below(32)));
        take_r(2 + rand_below(6), d0);
      join
      take_r(rand_below(6), d1);
    end

    // UART strobes
    for (int i = 0; i < 8; i++) begin
      rv = next_rand();
      write_word(soc_pkg::UART_TX_ADDR, next_rand(), {rv[3:1], 1'b1}, rand_below(3));
      write_word(soc_pkg::UART_TX_ADDR, next_rand(), {rv[3:1], 1'b0}, rand_below(3));
    end

    // CLINT mtime
    read_word(soc_pkg::CLINT_MTIME_ADDR, 0, d0);
    repeat (12) @(negedge clk);
    read_word(soc_pkg::CLINT_MTIME_ADDR, 0, d1);
    if (d1 < d0 + 32'd10)
      value_mismatch($sformatf("mtime moved from %0d to %0d", d0, d1));
    read_word(soc_pkg::CLINT_MTIME_ADDR + 32'd4, rand_below(3), d0);

    // Decode errors
    for (int i = 0; i < 8; i++) begin
      read_word(next_rand() & 32'h7FFF_FFFC, rand_below(4), d0);
      rv = next_rand();
      write_word(next_rand() & 32'h7FFF_FFFC, next_rand(), rv[3:0], rand_below(4));
    end
    read_word(32'hA000_0050, 1, d0);
    read_word(soc_pkg::UART_TX_ADDR, 2, d0);
    write_word(soc_pkg::CLINT_MTIME_ADDR, 32'h1234_5678, 4'hF, 1);

    repeat (4) @(negedge clk);
    if (skip_seen != exp_skip)
      value_mismatch($sformatf("skip pulses %0d, expected %0d", skip_seen, exp_skip));
    if (exp_r_q.size() != 0 || exp_b_q.size() != 0)
      protocol_fault("responses still missing at the end of the run");
    if (exp_uart_q.size() != 0)
      protocol_fault("UART strobes still missing at the end of the run");
    if (ar_wait_cycles == 0)
      protocol_fault("no read address ever waited behind a pending response");
    finish_run(1'b0);
  end

endmodule

// File: sim/xbar_sva.sv
`timescale 1ns/1ns

module xbar_sva (
  input logic clk,
  input logic rstn,
  input logic ar_valid,
  input logic ar_ready,
  input logic r_valid,
  input logic r_ready,
  input logic aw_valid,
  input logic aw_ready,
  input logic b_valid,
  input logic b_ready,
  input logic sram_ar_valid,
  input logic clint_ar_valid,
  input logic sram_aw_valid,
  input logic uart_aw_valid,
  input logic skip
);

  int   fail_count = 0;
  logic rd_open;
  logic wr_open;

  // Gate state as seen from the master handshakes
  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_open <= 1'b1;
      wr_open <= 1'b1;
    end else begin
      if (ar_valid && ar_ready)
        rd_open <= 1'b0;
      else if (r_valid && r_ready)
        rd_open <= 1'b1;
      if (aw_valid && aw_ready)
        wr_open <= 1'b0;
      else if (b_valid && b_ready)
        wr_open <= 1'b1;
    end
  end

  // Address valids only pass an open gate
  rd_gate_closed: assert property (@(posedge clk) disable iff (rstn)
    !rd_open |-> !(sram_ar_valid || clint_ar_valid))
    else begin
      $error("read address forwarded while the read gate is closed");
      fail_count++;
    end

  wr_gate_closed: assert property (@(posedge clk) disable iff (rstn)
    !wr_open |-> !(sram_aw_valid || uart_aw_valid))
    else begin
      $error("write address forwarded while the write gate is closed");
      fail_count++;
    end

  ar_one_slave: assert property (@(posedge clk) disable iff (rstn)
    $onehot0({sram_ar_valid, clint_ar_valid}))
    else begin
      $error("more than one slave sees ar_valid");
      fail_count++;
    end

  skip_single: assert property (@(posedge clk) disable iff (rstn)
    skip |=> !skip)
    else begin
      $error("skip high for two cycles in a row");
      fail_count++;
    end

  r_hold: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid)
    else begin
      $error("r_valid dropped before r_ready");
      fail_count++;
    end

endmodule

// File: hw/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top #(
  parameter int SRAM_ADDR_W = 8
) (
  input  logic             clk,
  input  logic             rstn,

  input  soc_pkg::axi_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  output soc_pkg::axi_r_t  r,
  output logic             r_valid,
  input  logic             r_ready,

  input  soc_pkg::axi_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  soc_pkg::axi_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  output soc_pkg::axi_b_t  b,
  output logic             b_valid,
  input  logic             b_ready,

  output logic [7:0]       uart_data,
  output logic             uart_valid,
  output logic             skip
);

  soc_pkg::axi_ar_t sram_ar, clint_ar;
  soc_pkg::axi_r_t  sram_r, clint_r;
  soc_pkg::axi_aw_t sram_aw, uart_aw;
  soc_pkg::axi_w_t  sram_w, uart_w;
  soc_pkg::axi_b_t  sram_b, uart_b;

  logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
  logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic sram_b_valid, sram_b_ready;
  logic uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic uart_b_valid, uart_b_ready;

  axi_xbar i_xbar (
    .clk            (clk),
    .rstn           (rstn),
    .ar             (ar),
    .ar_valid       (ar_valid),
    .ar_ready       (ar_ready),
    .r              (r),
    .r_valid        (r_valid),
    .r_ready        (r_ready),
    .aw             (aw),
    .aw_valid       (aw_valid),
    .aw_ready       (aw_ready),
    .w              (w),
    .w_valid        (w_valid),
    .w_ready        (w_ready),
    .b              (b),
    .b_valid        (b_valid),
    .b_ready        (b_ready),
    .sram_ar        (sram_ar),
    .sram_ar_valid  (sram_ar_valid),
    .sram_ar_ready  (sram_ar_ready),
    .sram_r         (sram_r),
    .sram_r_valid   (sram_r_valid),
    .sram_r_ready   (sram_r_ready),
    .clint_ar       (clint_ar),
    .clint_ar_valid (clint_ar_valid),
    .clint_ar_ready (clint_ar_ready),
    .clint_r        (clint_r),
    .clint_r_valid  (clint_r_valid),
    .clint_r_ready  (clint_r_ready),
    .sram_aw        (sram_aw),
    .sram_aw_valid  (sram_aw_valid),
    .sram_aw_ready  (sram_aw_ready),
    .sram_w         (sram_w),
    .sram_w_valid   (sram_w_valid),
    .sram_w_ready   (sram_w_ready),
    .sram_b         (sram_b),
    .sram_b_valid   (sram_b_valid),
    .sram_b_ready   (sram_b_ready),
    .uart_aw        (uart_aw),
    .uart_aw_valid  (uart_aw_valid),
    .uart_aw_ready  (uart_aw_ready),
    .uart_w         (uart_w),
    .uart_w_valid   (uart_w_valid),
    .uart_w_ready   (uart_w_ready),
    .uart_b         (uart_b),
    .uart_b_valid   (uart_b_valid),
    .uart_b_ready   (uart_b_ready),
    .skip           (skip)
  );

  sram_slave #(
    .ADDR_W (SRAM_ADDR_W)
  ) i_sram (
    .clk           (clk),
    .rstn          (rstn),
    .sram_ar       (sram_ar),
    .sram_ar_valid (sram_ar_valid),
    .sram_ar_ready (sram_ar_ready),
    .sram_r        (sram_r),
    .sram_r_valid  (sram_r_valid),
    .sram_r_ready  (sram_r_ready),
    .sram_aw       (sram_aw),
    .sram_aw_valid (sram_aw_valid),
    .sram_aw_ready (sram_aw_ready),
    .sram_w        (sram_w),
    .sram_w_valid  (sram_w_valid),
    .sram_w_ready  (sram_w_ready),
    .sram_b        (sram_b),
    .sram_b_valid  (sram_b_valid),
    .sram_b_ready  (sram_b_ready)
  );

  clint i_clint (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (clint_ar),
    .ar_valid (clint_ar_valid),
    .ar_ready (clint_ar_ready),
    .r        (clint_r),
    .r_valid  (clint_r_valid),
    .r_ready  (clint_r_ready)
  );

  uart_tx_port i_uart (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (uart_aw),
    .aw_valid (uart_aw_valid),
    .aw_ready (uart_aw_ready),
    .w        (uart_w),
    .w_valid  (uart_w_valid),
    .w_ready  (uart_w_ready),
    .b        (uart_b),
    .b_valid  (uart_b_valid),
    .b_ready  (uart_b_ready),
    .tx_data  (uart_data),
    .tx_valid (uart_valid)
  );

endmodule

// File: hw/uart_tx_port.sv
`timescale 1ns/1ns

module uart_tx_port (
  input  logic             clk,
  input  logic             rstn,

  input  soc_pkg::axi_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  soc_pkg::axi_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  output soc_pkg::axi_b_t  b,
  output logic             b_valid,
  input  logic             b_ready,

  output logic [7:0]       tx_data,
  output logic             tx_valid
);

  typedef enum logic [1:0] {US_ADDR, US_DATA, US_RESP} uart_state_e;

  uart_state_e state;

  assign aw_ready = (state == US_ADDR);
  assign w_ready  = (state == US_DATA);
  assign b_valid  = (state == US_RESP);
  assign b.resp   = soc_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state <= US_ADDR;
    end else begin
      case (state)
        US_ADDR: if (aw_valid) state <= US_DATA;
        US_DATA: if (w_valid) state <= US_RESP;
        default: if (b_ready) state <= US_ADDR;
      endcase
    end
  end

  // One-cycle byte strobe after W
  always_ff @(posedge clk) begin
    if (rstn)
      tx_valid <= 1'b0;
    else
      tx_valid <= w_valid & w_ready & w.strb[0];
  end

  always_ff @(posedge clk) begin
    if (w_valid && w_ready)
      tx_data <= w.data[7:0];
  end

endmodule

// File: hw/clint.sv
`timescale 1ns/1ns

module clint (
  input  logic             clk,
  input  logic             rstn,

  input  soc_pkg::axi_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  output soc_pkg::axi_r_t  r,
  output logic             r_valid,
  input  logic             r_ready
);

  logic [63:0] mtime;
  logic [31:0] rd_data;

  always_ff @(posedge clk) begin
    if (rstn)
      mtime <= '0;
    else
      mtime <= mtime + 64'd1;
  end

  assign ar_ready = ~r_valid;
  assign r.data   = rd_data;
  assign r.resp   = soc_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn)
      r_valid <= 1'b0;
    else if (ar_valid && ar_ready)
      r_valid <= 1'b1;
    else if (r_ready)
      r_valid <= 1'b0;
  end

  // Half picked by address bit 2, sampled at acceptance
  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready)
      rd_data <= ar.addr[2] ? mtime[63:32] : mtime[31:0];
  end

endmodule

// File: hw/sram_slave.sv
`timescale 1ns/1ns

module sram_slave #(
  parameter int ADDR_W = 8  // Word address bits
) (
  input  logic             clk,
  input  logic             rstn,

  input  soc_pkg::axi_ar_t sram_ar,
  input  logic             sram_ar_valid,
  output logic             sram_ar_ready,
  output soc_pkg::axi_r_t  sram_r,
  output logic             sram_r_valid,
  input  logic             sram_r_ready,

  input  soc_pkg::axi_aw_t sram_aw,
  input  logic             sram_aw_valid,
  output logic             sram_aw_ready,
  input  soc_pkg::axi_w_t  sram_w,
  input  logic             sram_w_valid,
  output logic             sram_w_ready,
  output soc_pkg::axi_b_t  sram_b,
  output logic             sram_b_valid,
  input  logic             sram_b_ready
);

  typedef enum logic [1:0] {WS_ADDR, WS_DATA, WS_RESP} wr_state_e;

  logic [31:0]       mem [0:(1 << ADDR_W) - 1];
  logic [31:0]       rd_data;
  logic [ADDR_W-1:0] wr_idx;
  wr_state_e         wr_state;

  // Read side
  assign sram_ar_ready = ~sram_r_valid;  // Idle when no response pending
  assign sram_r.data   = rd_data;
  assign sram_r.resp   = soc_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn)
      sram_r_valid <= 1'b0;
    else if (sram_ar_valid && sram_ar_ready)
      sram_r_valid <= 1'b1;
    else if (sram_r_ready)
      sram_r_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (sram_ar_valid && sram_ar_ready)
      rd_data <= mem[sram_ar.addr[ADDR_W+1:2]];
  end

  // Write side
  assign sram_aw_ready = (wr_state == WS_ADDR);
  assign sram_w_ready  = (wr_state == WS_DATA);
  assign sram_b_valid  = (wr_state == WS_RESP);
  assign sram_b.resp   = soc_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_state <= WS_ADDR;
    end else begin
      case (wr_state)
        WS_ADDR: if (sram_aw_valid) wr_state <= WS_DATA;
        WS_DATA: if (sram_w_valid) wr_state <= WS_RESP;
        default: if (sram_b_ready) wr_state <= WS_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sram_aw_valid && sram_aw_ready)
      wr_idx <= sram_aw.addr[ADDR_W+1:2];
  end

  // Byte lanes under strobe
  always_ff @(posedge clk) begin
    if (sram_w_valid && sram_w_ready) begin
      for (int i = 0; i < 4; i++) begin
        if (sram_w.strb[i])
          mem[wr_idx][i*8 +: 8] <= sram_w.data[i*8 +: 8];
      end
    end
  end

endmodule

// File: hw/axi_xbar.sv
`timescale 1ns/1ns

module axi_xbar (
  input  logic             clk,
  input  logic             rstn,

  input  soc_pkg::axi_ar_t ar,
  input  logic             ar_valid,
  output logic             ar_ready,
  output soc_pkg::axi_r_t  r,
  output logic             r_valid,
  input  logic             r_ready,

  input  soc_pkg::axi_aw_t aw,
  input  logic             aw_valid,
  output logic             aw_ready,
  input  soc_pkg::axi_w_t  w,
  input  logic             w_valid,
  output logic             w_ready,
  output soc_pkg::axi_b_t  b,
  output logic             b_valid,
  input  logic             b_ready,

  output soc_pkg::axi_ar_t sram_ar,
  output logic             sram_ar_valid,
  input  logic             sram_ar_ready,
  input  soc_pkg::axi_r_t  sram_r,
  input  logic             sram_r_valid,
  output logic             sram_r_ready,

  output soc_pkg::axi_ar_t clint_ar,
  output logic             clint_ar_valid,
  input  logic             clint_ar_ready,
  input  soc_pkg::axi_r_t  clint_r,
  input  logic             clint_r_valid,
  output logic             clint_r_ready,

  output soc_pkg::axi_aw_t sram_aw,
  output logic             sram_aw_valid,
  input  logic             sram_aw_ready,
  output soc_pkg::axi_w_t  sram_w,
  output logic             sram_w_valid,
  input  logic             sram_w_ready,
  input  soc_pkg::axi_b_t  sram_b,
  input  logic             sram_b_valid,
  output logic             sram_b_ready,

  output soc_pkg::axi_aw_t uart_aw,
  output logic             uart_aw_valid,
  input  logic             uart_aw_ready,
  output soc_pkg::axi_w_t  uart_w,
  output logic             uart_w_valid,
  input  logic             uart_w_ready,
  input  soc_pkg::axi_b_t  uart_b,
  input  logic             uart_b_valid,
  output logic             uart_b_ready,

  output logic             skip
);

  typedef enum logic [1:0] {RD_IDLE, RD_SRAM, RD_CLINT, RD_ERR} rd_route_e;
  typedef enum logic [2:0] {WR_IDLE, WR_SRAM, WR_UART, WR_ERR_DATA, WR_ERR_RESP} wr_route_e;

  rd_route_e rd_route;
  wr_route_e wr_route;
  logic      rd_gate, wr_gate;
  logic      rd_hit_sram, rd_hit_clint;
  logic      wr_hit_sram, wr_hit_uart;
  logic      ar_hs, aw_hs;

  assign rd_gate = (rd_route == RD_IDLE);
  assign wr_gate = (wr_route == WR_IDLE);

  // Address decode
  assign rd_hit_sram  = (ar.addr[31:27] == soc_pkg::SRAM_BASE_TAG);
  assign rd_hit_clint = (ar.addr[31:3] == soc_pkg::CLINT_MTIME_ADDR[31:3]);
  assign wr_hit_sram  = (aw.addr[31:27] == soc_pkg::SRAM_BASE_TAG);
  assign wr_hit_uart  = (aw.addr == soc_pkg::UART_TX_ADDR);

  // Read request
  assign sram_ar        = ar;
  assign clint_ar       = ar;
  assign sram_ar_valid  = rd_gate & ar_valid & rd_hit_sram;
  assign clint_ar_valid = rd_gate & ar_valid & rd_hit_clint;

  always_comb begin
    if (!rd_gate)
      ar_ready = 1'b0;
    else if (rd_hit_sram)
      ar_ready = sram_ar_ready;
    else if (rd_hit_clint)
      ar_ready = clint_ar_ready;
    else
      ar_ready = 1'b1;  // Unmapped, taken by the error responder
  end

  assign ar_hs = ar_valid & ar_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_route <= RD_IDLE;
    end else if (rd_route == RD_IDLE) begin
      if (ar_hs) begin
        if (rd_hit_sram)
          rd_route <= RD_SRAM;
        else if (rd_hit_clint)
          rd_route <= RD_CLINT;
        else
          rd_route <= RD_ERR;
      end
    end else if (r_valid && r_ready) begin
      rd_route <= RD_IDLE;
    end
  end

  // Read response
  always_comb begin
    r             = '0;
    r_valid       = 1'b0;
    sram_r_ready  = 1'b0;
    clint_r_ready = 1'b0;
    case (rd_route)
      RD_SRAM: begin
        r            = sram_r;
        r_valid      = sram_r_valid;
        sram_r_ready = r_ready;
      end
      RD_CLINT: begin
        r             = clint_r;
        r_valid       = clint_r_valid;
        clint_r_ready = r_ready;
      end
      RD_ERR: begin
        r.resp  = soc_pkg::RESP_DECERR;
        r_valid = 1'b1;
      end
      default: ;
    endcase
  end

  // Write request
  assign sram_aw       = aw;
  assign uart_aw       = aw;
  assign sram_aw_valid = wr_gate & aw_valid & wr_hit_sram;
  assign uart_aw_valid = wr_gate & aw_valid & wr_hit_uart;

  always_comb begin
    if (!wr_gate)
      aw_ready = 1'b0;
    else if (wr_hit_sram)
      aw_ready = sram_aw_ready;
    else if (wr_hit_uart)
      aw_ready = uart_aw_ready;
    else
      aw_ready = 1'b1;
  end

  assign aw_hs = aw_valid & aw_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_route <= WR_IDLE;
    end else begin
      case (wr_route)
        WR_IDLE: begin
          if (aw_hs) begin
            if (wr_hit_sram)
              wr_route <= WR_SRAM;
            else if (wr_hit_uart)
              wr_route <= WR_UART;
            else
              wr_route <= WR_ERR_DATA;
          end
        end
        WR_ERR_DATA: begin
          if (w_valid)
            wr_route <= WR_ERR_RESP;  // W sunk, answer next cycle
        end
        default: begin
          if (b_valid && b_ready)
            wr_route <= WR_IDLE;
        end
      endcase
    end
  end

  // Write data and response, only toward the recorded slave
  assign sram_w = w;
  assign uart_w = w;

  always_comb begin
    sram_w_valid = 1'b0;
    uart_w_valid = 1'b0;
    sram_b_ready = 1'b0;
    uart_b_ready = 1'b0;
    w_ready      = 1'b0;
    b            = '0;
    b_valid      = 1'b0;
    case (wr_route)
      WR_SRAM: begin
        sram_w_valid = w_valid;
        w_ready      = sram_w_ready;
        b            = sram_b;
        b_valid      = sram_b_valid;
        sram_b_ready = b_ready;
      end
      WR_UART: begin
        uart_w_valid = w_valid;
        w_ready      = uart_w_ready;
        b            = uart_b;
        b_valid      = uart_b_valid;
        uart_b_ready = b_ready;
      end
      WR_ERR_DATA: w_ready = 1'b1;
      WR_ERR_RESP: begin
        b.resp  = soc_pkg::RESP_DECERR;
        b_valid = 1'b1;
      end
      default: ;
    endcase
  end

  // Difftest skip for every non-SRAM access
  always_ff @(posedge clk) begin
    if (rstn)
      skip <= 1'b0;
    else
      skip <= (ar_hs & ~rd_hit_sram) | (aw_hs & ~wr_hit_sram);
  end

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

  // Read address channel
  typedef struct packed {
    logic [31:0] addr;
  } axi_ar_t;

  // Read data channel
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  // Write address channel
  typedef struct packed {
    logic [31:0] addr;
  } axi_aw_t;

  // Write data channel
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  // Write response channel
  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_DECERR = 2'd3;

  // Address map
  localparam logic [4:0]  SRAM_BASE_TAG    = 5'b10000;       // 0x8000_0000 .. 0x87FF_FFFF
  localparam logic [31:0] CLINT_MTIME_ADDR = 32'hA000_0048;  // Low word, high word at +4
  localparam logic [31:0] UART_TX_ADDR     = 32'hA000_03F8;

endpackage
